// File: hw/cam_pkg.sv
package cam_pkg;

   // Bus and data widths
   localparam int ADDR_W  = 6;
   localparam int DATA_W  = 32;
   localparam int PIXEL_W = 10;   // RAW10
   localparam int WORD_W  = 32;
   localparam int CMD_W   = 8;

   typedef logic [ADDR_W-1:0]  reg_addr_t;
   typedef logic [DATA_W-1:0]  reg_data_t;
   typedef logic [PIXEL_W-1:0] pixel_t;
   typedef logic [WORD_W-1:0]  fifo_word_t;
   typedef logic [CMD_W-1:0]   cmd_byte_t;

   // ASCII command bytes
   localparam cmd_byte_t CMD_CODE_CAPTURE       = 8'h63;   // 'c'
   localparam cmd_byte_t CMD_CODE_READ_CTRL     = 8'h66;   // 'f'
   localparam cmd_byte_t CMD_CODE_READ_CONFIG   = 8'h67;   // 'g'
   localparam cmd_byte_t CMD_CODE_WRITE_CONFIG2 = 8'h68;   // 'h'
   localparam cmd_byte_t CMD_CODE_WRITE_CONFIG3 = 8'h69;   // 'i'

   // Receiver register map, byte addresses
   localparam reg_addr_t REG_CTRL_ADDR   = 6'h00;   // Bit 0 enables the receiver
   localparam reg_addr_t REG_CONFIG_ADDR = 6'h04;

   localparam reg_data_t CTRL_ENABLE  = 32'd1;
   localparam reg_data_t CTRL_DISABLE = 32'd0;
   localparam reg_data_t CFG_MODE2    = 32'd2;
   localparam reg_data_t CFG_MODE3    = 32'd3;

   // Output FIFO
   localparam int FIFO_DEPTH       = 16;
   localparam int FIFO_ALMOST_FULL = 8;    // Capture pauses here
   localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W       = FIFO_PTR_W + 1;

   // Line start/end checking
   localparam int LINE_ERR_W = 4;
   localparam int LINE_CNT_W = 12;

   typedef enum logic [2:0]
   {
      CMD_CAPTURE,
      CMD_READ_CTRL,
      CMD_READ_CONFIG,
      CMD_WRITE_CONFIG2,
      CMD_WRITE_CONFIG3
   } cmd_t;

   typedef enum logic [3:0]
   {
      IDLE,
      ENABLE,
      WAIT_FS,
      STREAM,
      PAUSE,
      WAIT_EMPTY,
      RESUME,
      STOP,
      REG_ACCESS,
      PUSH_READ
   } ctrl_state_t;

endpackage

// File: hw/reg_req_if.sv
`timescale 1ns/1ps

interface reg_req_if;
   import cam_pkg::*;

   logic      req_valid;   // Held until the cycle after req_done
   logic      req_write;
   reg_addr_t req_addr;
   reg_data_t req_wdata;
   logic      req_done;    // One-cycle pulse
   reg_data_t req_rdata;   // Valid with req_done on reads

   modport ctrl
   (
      output req_valid,
      output req_write,
      output req_addr,
      output req_wdata,
      input  req_done,
      input  req_rdata
   );

   modport master
   (
      input  req_valid,
      input  req_write,
      input  req_addr,
      input  req_wdata,
      output req_done,
      output req_rdata
   );

endinterface

// File: hw/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode
(
   input  logic               bus_clk,
   input  logic               arst_n,
   input  cam_pkg::cmd_byte_t in_data,
   input  logic               in_valid,
   output logic               in_ready,
   output cam_pkg::cmd_t      cmd,
   output logic               cmd_valid,
   input  logic               cmd_ready
);
   import cam_pkg::*;

   cmd_t dec_cmd;
   logic dec_hit;
   logic accept;

   assign in_ready = !cmd_valid;   // Stall while a command waits
   assign accept   = in_valid && in_ready;

   always_comb
   begin
      dec_hit = 1'b1;
      dec_cmd = CMD_CAPTURE;
      case (in_data)
         CMD_CODE_CAPTURE:       dec_cmd = CMD_CAPTURE;
         CMD_CODE_READ_CTRL:     dec_cmd = CMD_READ_CTRL;
         CMD_CODE_READ_CONFIG:   dec_cmd = CMD_READ_CONFIG;
         CMD_CODE_WRITE_CONFIG2: dec_cmd = CMD_WRITE_CONFIG2;
         CMD_CODE_WRITE_CONFIG3: dec_cmd = CMD_WRITE_CONFIG3;
         default:                dec_hit = 1'b0;   // Unknown byte is dropped
      endcase
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cmd_valid <= 1'b0;
      end
      else if (cmd_valid && cmd_ready)
      begin
         cmd_valid <= 1'b0;
      end
      else if (accept && dec_hit)
      begin
         cmd_valid <= 1'b1;
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (accept)
      begin
         cmd <= dec_cmd;
      end
   end

endmodule

// File: hw/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl
(
   input  logic                              bus_clk,
   input  logic                              arst_n,
   input  cam_pkg::cmd_t                     cmd,
   input  logic                              cmd_valid,
   output logic                              cmd_ready,
   reg_req_if.ctrl                           req,
   input  cam_pkg::pixel_t                   pixel,
   input  logic                              pixel_valid,
   input  logic                              fs,
   input  logic                              fe,
   input  logic                              ls,
   input  logic                              le,
   output logic                              push,
   output cam_pkg::fifo_word_t               push_data,
   input  logic                              fifo_almost_full,
   input  logic                              fifo_full,
   input  logic                              fifo_empty,
   output logic [cam_pkg::LINE_ERR_W-1:0]    line_err_count
);
   import cam_pkg::*;

   ctrl_state_t           state;
   cmd_t                  cur_cmd;
   reg_data_t             read_word;
   logic                  req_valid_q;
   logic                  fe_seen;     // Frame ended while paused
   logic                  capturing;
   logic                  cmd_is_read;
   logic [LINE_CNT_W-1:0] ls_count;
   logic [LINE_CNT_W-1:0] le_count;

   assign cmd_ready     = (state == IDLE);
   assign req.req_valid = req_valid_q;
   assign cmd_is_read   = (cur_cmd == CMD_READ_CTRL) || (cur_cmd == CMD_READ_CONFIG);

   // Pixels may still arrive around a disable or enable write
   assign capturing = (state == STREAM) || (state == PAUSE) ||
                      (state == WAIT_EMPTY) || (state == RESUME);

   // Request fields follow the state, so they hold until req_done
   always_comb
   begin
      req.req_write = 1'b1;
      req.req_addr  = REG_CTRL_ADDR;
      req.req_wdata = CTRL_DISABLE;
      case (state)
         ENABLE, RESUME:
         begin
            req.req_wdata = CTRL_ENABLE;
         end
         REG_ACCESS:
         begin
            req.req_write = !cmd_is_read;
            if (cur_cmd != CMD_READ_CTRL)
               req.req_addr = REG_CONFIG_ADDR;
            if (cur_cmd == CMD_WRITE_CONFIG3)
               req.req_wdata = CFG_MODE3;
            else
               req.req_wdata = CFG_MODE2;
         end
         default:
         begin
         end
      endcase
   end

   always_comb
   begin
      push      = 1'b0;
      push_data = fifo_word_t'(pixel);   // Zero-extended pixel
      if (state == PUSH_READ)
      begin
         push      = 1'b1;
         push_data = read_word;
      end
      else if (capturing && pixel_valid && !fifo_full)
      begin
         push = 1'b1;
      end
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state          <= IDLE;
         req_valid_q    <= 1'b0;
         fe_seen        <= 1'b0;
         ls_count       <= '0;
         le_count       <= '0;
         line_err_count <= '0;
      end
      else
      begin
         if (req.req_done)
            req_valid_q <= 1'b0;

         case (state)
            IDLE:
            begin
               if (cmd_valid)
               begin
                  req_valid_q <= 1'b1;
                  if (cmd == CMD_CAPTURE)
                  begin
                     state    <= ENABLE;
                     fe_seen  <= 1'b0;
                     ls_count <= '0;
                     le_count <= '0;
                  end
                  else
                  begin
                     state <= REG_ACCESS;
                  end
               end
            end
            ENABLE:
               if (req.req_done) state <= WAIT_FS;
            WAIT_FS:
               if (fs) state <= STREAM;
            STREAM:
            begin
               if (fe || fe_seen)
               begin
                  state       <= STOP;
                  req_valid_q <= 1'b1;
               end
               else if (fifo_almost_full)
               begin
                  state       <= PAUSE;
                  req_valid_q <= 1'b1;
               end
            end
            PAUSE:
               if (req.req_done) state <= WAIT_EMPTY;
            WAIT_EMPTY:
            begin
               if (fifo_empty && fe_seen)
               begin
                  state <= IDLE;   // Receiver already disabled
               end
               else if (fifo_empty)
               begin
                  state       <= RESUME;
                  req_valid_q <= 1'b1;
               end
            end
            RESUME:
               if (req.req_done) state <= STREAM;
            STOP:
               if (req.req_done) state <= IDLE;
            REG_ACCESS:
               if (req.req_done) state <= cmd_is_read ? PUSH_READ : IDLE;
            PUSH_READ:
               state <= IDLE;
            default:
               state <= IDLE;
         endcase

         if (capturing && fe)
            fe_seen <= 1'b1;

         if (capturing && ls)
         begin
            if (ls_count != le_count)
            begin
               line_err_count <= line_err_count + 1'b1;
               le_count       <= ls_count;   // Resync after a missing le
            end
            ls_count <= ls_count + 1'b1;
         end
         if (capturing && le)
            le_count <= le_count + 1'b1;
      end
   end

   // Command and read result payload
   always_ff @(posedge bus_clk)
   begin
      if (cmd_valid && cmd_ready)
         cur_cmd <= cmd;
      if (req.req_done)
         read_word <= req.req_rdata;
   end

endmodule

// File: hw/axil_reg_master.sv
`timescale 1ns/1ps

module axil_reg_master
(
   input  logic               bus_clk,
   input  logic               arst_n,
   reg_req_if.master          req,
   output cam_pkg::reg_addr_t awaddr,
   output logic               awvalid,
   input  logic               awready,
   output cam_pkg::reg_data_t wdata,
   output logic               wvalid,
   input  logic               wready,
   input  logic               bvalid,
   output logic               bready,
   output cam_pkg::reg_addr_t araddr,
   output logic               arvalid,
   input  logic               arready,
   input  cam_pkg::reg_data_t rdata,
   input  logic               rvalid,
   output logic               rready
);
   import cam_pkg::*;

   reg_data_t rdata_q;
   logic      busy;
   logic      start;

   // Request fields are stable for the whole transaction
   assign awaddr = req.req_addr;
   assign araddr = req.req_addr;
   assign wdata  = req.req_wdata;

   assign busy  = awvalid || wvalid || bready || arvalid || rready;
   assign start = req.req_valid && !busy && !req.req_done;   // req_valid lingers a cycle

   assign req.req_rdata = rdata_q;

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         awvalid      <= 1'b0;
         wvalid       <= 1'b0;
         bready       <= 1'b0;
         arvalid      <= 1'b0;
         rready       <= 1'b0;
         req.req_done <= 1'b0;
      end
      else
      begin
         req.req_done <= 1'b0;

         if (start && req.req_write)
         begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            bready  <= 1'b1;
         end
         if (start && !req.req_write)
         begin
            arvalid <= 1'b1;
            rready  <= 1'b1;
         end

         // Address and data channels complete independently
         if (awvalid && awready)
            awvalid <= 1'b0;
         if (wvalid && wready)
            wvalid <= 1'b0;
         if (arvalid && arready)
            arvalid <= 1'b0;

         if (bready && bvalid)
         begin
            bready       <= 1'b0;
            req.req_done <= 1'b1;   // Response code ignored
         end
         if (rready && rvalid)
         begin
            rready       <= 1'b0;
            req.req_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (rready && rvalid)
         rdata_q <= rdata;
   end

endmodule

// File: hw/result_fifo.sv
`timescale 1ns/1ps

module result_fifo
(
   input  logic                bus_clk,
   input  logic                arst_n,
   input  logic                push,
   input  cam_pkg::fifo_word_t push_data,
   output logic                fifo_full,
   output logic                fifo_almost_full,
   output logic                fifo_empty,
   output cam_pkg::fifo_word_t out_data,
   output logic                out_valid,
   input  logic                out_ready
);
   import cam_pkg::*;

   fifo_word_t            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;
   logic                  wr_en;
   logic                  rd_en;

   assign wr_en = push && !fifo_full;   // Push into a full FIFO is lost
   assign rd_en = out_valid && out_ready;

   assign fifo_full        = (count == FIFO_CNT_W'(FIFO_DEPTH));
   assign fifo_almost_full = (count >= FIFO_CNT_W'(FIFO_ALMOST_FULL));
   assign fifo_empty       = (count == '0);

   // Head word shows without a read request
   assign out_data  = mem[rd_ptr];
   assign out_valid = !fifo_empty;

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;

         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= push_data;
   end

endmodule

// File: hw/cam_bridge_top.sv
`timescale 1ns/1ps

module cam_bridge_top
(
   input  logic                           bus_clk,
   input  logic                           arst_n,
   // Command bytes
   input  cam_pkg::cmd_byte_t             in_data,
   input  logic                           in_valid,
   output logic                           in_ready,
   // Receiver pixel port
   input  cam_pkg::pixel_t                pixel,
   input  logic                           pixel_valid,
   input  logic                           fs,
   input  logic                           fe,
   input  logic                           ls,
   input  logic                           le,
   // AXI4-Lite to the receiver registers
   output cam_pkg::reg_addr_t             awaddr,
   output logic                           awvalid,
   input  logic                           awready,
   output cam_pkg::reg_data_t             wdata,
   output logic                           wvalid,
   input  logic                           wready,
   input  logic                           bvalid,
   output logic                           bready,
   output cam_pkg::reg_addr_t             araddr,
   output logic                           arvalid,
   input  logic                           arready,
   input  cam_pkg::reg_data_t             rdata,
   input  logic                           rvalid,
   output logic                           rready,
   // Host side
   output cam_pkg::fifo_word_t            out_data,
   output logic                           out_valid,
   input  logic                           out_ready,
   output logic [cam_pkg::LINE_ERR_W-1:0] line_err_count   // To the LEDs
);
   import cam_pkg::*;

   cmd_t       cmd;
   logic       cmd_valid;
   logic       cmd_ready;
   logic       push;
   fifo_word_t push_data;
   logic       fifo_full;
   logic       fifo_almost_full;
   logic       fifo_empty;

   reg_req_if req_bus ();

   cmd_decode u_decode
   (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .in_data   (in_data),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready)
   );

   capture_ctrl u_ctrl
   (
      .bus_clk          (bus_clk),
      .arst_n           (arst_n),
      .cmd              (cmd),
      .cmd_valid        (cmd_valid),
      .cmd_ready        (cmd_ready),
      .req              (req_bus.ctrl),
      .pixel            (pixel),
      .pixel_valid      (pixel_valid),
      .fs               (fs),
      .fe               (fe),
      .ls               (ls),
      .le               (le),
      .push             (push),
      .push_data        (push_data),
      .fifo_almost_full (fifo_almost_full),
      .fifo_full        (fifo_full),
      .fifo_empty       (fifo_empty),
      .line_err_count   (line_err_count)
   );

   axil_reg_master u_axil
   (
      .bus_clk (bus_clk),
      .arst_n  (arst_n),
      .req     (req_bus.master),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   result_fifo u_fifo
   (
      .bus_clk          (bus_clk),
      .arst_n           (arst_n),
      .push             (push),
      .push_data        (push_data),
      .fifo_full        (fifo_full),
      .fifo_almost_full (fifo_almost_full),
      .fifo_empty       (fifo_empty),
      .out_data         (out_data),
      .out_valid        (out_valid),
      .out_ready        (out_ready)
   );

endmodule

// File: verif/csi_rx_model.sv
`timescale 1ns/1ps

module csi_rx_model
(
   input  logic                bus_clk,
   input  logic                arst_n,
   // AXI4-Lite register slave
   input  cam_pkg::reg_addr_t  awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  cam_pkg::reg_data_t  wdata,
   input  logic                wvalid,
   output logic                wready,
   output logic                bvalid,
   input  logic                bready,
   input  cam_pkg::reg_addr_t  araddr,
   input  logic                arvalid,
   output logic                arready,
   output cam_pkg::reg_data_t  rdata,
   output logic                rvalid,
   input  logic                rready,
   // Pixel port
   output cam_pkg::pixel_t     pixel,
   output logic                pixel_valid,
   output logic                fs,
   output logic                fe,
   output logic                ls,
   output logic                le,
   // Frame control from the testbench
   input  logic                frame_req,
   input  int                  frame_lines,
   input  int                  frame_pixels,
   input  int                  omit_le_line,   // -1 keeps every le
   output logic                frame_busy,
   output cam_pkg::reg_data_t  ctrl_reg,
   output cam_pkg::reg_data_t  cfg_reg
);
   import cam_pkg::*;

   logic [31:0] pix_state;
   logic [31:0] dly_state;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic tick();
      @(posedge bus_clk);
      #1;
   endtask

   // Ready after 1 to 3 cycles, two LFSR bits per pick
   task automatic ready_delay();
      logic [1:0] pick;
      pick[0]   = dly_state[0];
      dly_state = lfsr_next(dly_state);
      pick[1]   = dly_state[0];
      dly_state = lfsr_next(dly_state);
      if (pick == 2'd3)
         pick = 2'd2;
      repeat (pick) tick();
   endtask

   // One frame beat, held back while the enable bit is clear
   task automatic drive_beat(input logic b_fs, input logic b_ls, input logic b_pv,
                             input logic b_le, input logic b_fe);
      @(posedge bus_clk);
      while (!ctrl_reg[0])
      begin
         #1;
         {fs, ls, pixel_valid, le, fe} = '0;
         @(posedge bus_clk);
      end
      #1;
      {fs, ls, pixel_valid, le, fe} = {b_fs, b_ls, b_pv, b_le, b_fe};
      if (b_pv)
      begin
         for (int i = 0; i < PIXEL_W; i++)
         begin
            pixel[i]  = pix_state[0];   // LSB first
            pix_state = lfsr_next(pix_state);
         end
      end
   endtask

   initial
   begin
      {awready, wready, bvalid, arready, rvalid} = '0;
      {fs, ls, pixel_valid, le, fe} = '0;
      rdata      = '0;
      pixel      = '0;
      frame_busy = 1'b0;
      ctrl_reg   = '0;
      cfg_reg    = '0;
      pix_state  = 32'hfd7b;
      dly_state  = 32'hfd7b;
   end

   always
   begin
      tick();
      if (arst_n && awvalid && wvalid)
      begin
         ready_delay();
         awready = 1'b1;
         wready  = 1'b1;
         tick();
         awready = 1'b0;
         wready  = 1'b0;
         if (awaddr == REG_CONFIG_ADDR)
            cfg_reg = wdata;
         else
            ctrl_reg = wdata;
         bvalid = 1'b1;
         @(negedge bus_clk);
         while (!bready) @(negedge bus_clk);
         tick();
         bvalid = 1'b0;
      end
      else if (arst_n && arvalid)
      begin
         ready_delay();
         arready = 1'b1;
         tick();
         arready = 1'b0;
         rdata   = (araddr == REG_CONFIG_ADDR) ? cfg_reg : ctrl_reg;
         rvalid  = 1'b1;
         @(negedge bus_clk);
         while (!rready) @(negedge bus_clk);
         tick();
         rvalid = 1'b0;
      end
   end

   // Frame generator
   always
   begin
      @(posedge bus_clk);
      if (arst_n && frame_req)
      begin
         #1;
         frame_busy = 1'b1;
         @(posedge bus_clk);
         while (!ctrl_reg[0]) @(posedge bus_clk);
         repeat (4) @(posedge bus_clk);   // Controller reaches WAIT_FS first
         drive_beat(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
         for (int l = 0; l < frame_lines; l++)
         begin
            drive_beat(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
            repeat (frame_pixels) drive_beat(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
            drive_beat(1'b0, 1'b0, 1'b0, (l != omit_le_line), 1'b0);
         end
         drive_beat(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
         tick();
         {fs, ls, pixel_valid, le, fe} = '0;
         frame_busy = 1'b0;
      end
   end

endmodule

// File: verif/tb_cam_bridge.sv
`timescale 1ns/1ps

module tb_cam_bridge;
   import cam_pkg::*;

   localparam logic [31:0] SEED = 32'hfd7b;
   localparam int NUM_CMDS    = 12;
   localparam int FRAME_BEATS = (2 * (4 + 2) + 2) + (4 * (10 + 2) + 2) + (3 * (4 + 2) + 2);
   localparam int CYCLE_LIMIT = 16 + NUM_CMDS * 50 + FRAME_BEATS * 8;

   logic                  bus_clk = 1'b0;
   logic                  arst_n;
   cmd_byte_t             in_data;
   logic                  in_valid;
   logic                  in_ready;
   pixel_t                pixel;
   logic                  pixel_valid, fs, fe, ls, le;
   reg_addr_t             awaddr, araddr;
   reg_data_t             wdata, rdata;
   logic                  awvalid, awready, wvalid, wready, bvalid, bready;
   logic                  arvalid, arready, rvalid, rready;
   fifo_word_t            out_data;
   logic                  out_valid;
   logic                  out_ready;
   logic [LINE_ERR_W-1:0] line_err_count;
   logic                  frame_req;
   int                    frame_lines, frame_pixels, omit_le_line;
   logic                  frame_busy;
   reg_data_t             rx_ctrl, rx_cfg;

   logic [31:0] exp_q[$];
   logic [31:0] expected_word;
   int          pix_index      = 0;
   int          error_count    = 0;
   int          word_count     = 0;
   int          axi_count      = 0;
   int          disable_writes = 0;
   int          cycle_count    = 0;

   always #20 bus_clk = ~bus_clk;

   cam_bridge_top dut
   (
      .bus_clk, .arst_n, .in_data, .in_valid, .in_ready,
      .pixel, .pixel_valid, .fs, .fe, .ls, .le,
      .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
      .out_data, .out_valid, .out_ready, .line_err_count
   );

   csi_rx_model rx
   (
      .bus_clk, .arst_n,
      .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
      .pixel, .pixel_valid, .fs, .fe, .ls, .le,
      .frame_req, .frame_lines, .frame_pixels, .omit_le_line, .frame_busy,
      .ctrl_reg (rx_ctrl),
      .cfg_reg  (rx_cfg)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // Expected FIFO word for the n-th pixel since reset, ten bits per pixel
   function automatic logic [31:0] ref_pixel_word(input int n);
      logic [31:0] s;
      logic [31:0] word;
      s    = SEED;
      word = '0;
      repeat (n * 10) s = lfsr_next(s);
      for (int i = 0; i < 10; i++)
      begin
         word[i] = s[0];
         s       = lfsr_next(s);
      end
      return word;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
      error_count++;
   endtask

   task automatic send_cmd(input cmd_byte_t b);
      in_data  = b;
      in_valid = 1'b1;
      @(negedge bus_clk);
      while (!in_ready) @(negedge bus_clk);
      @(posedge bus_clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic start_frame(input int n_lines, input int n_pixels, input int omit);
      frame_lines  = n_lines;
      frame_pixels = n_pixels;
      omit_le_line = omit;
      frame_req    = 1'b1;
      do @(posedge bus_clk); while (!frame_busy);
      #1;
      frame_req = 1'b0;
   endtask

   task automatic expect_pixels(input int n);
      repeat (n)
      begin
         exp_q.push_back(ref_pixel_word(pix_index));
         pix_index++;
      end
   endtask

   task automatic wait_drained();
      do @(posedge bus_clk); while (exp_q.size() != 0);
      #1;
   endtask

   // Compare every word that leaves the output port
   always @(negedge bus_clk)
   begin
      if (arst_n && out_valid && out_ready)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Unexpected word 0x%0h on out_data at %0t ns", out_data, $time);
            error_count++;
         end
         else
         begin
            expected_word = exp_q.pop_front();
            word_count++;
            if (out_data !== expected_word)
               report_mismatch("out_data", out_data, expected_word);
         end
      end
   end

   // AXI handshakes seen one half cycle ahead of the edge
   always @(negedge bus_clk)
   begin
      if (wvalid && wready)
      begin
         axi_count++;
         if (awaddr == REG_CTRL_ADDR && wdata == 32'd0)
            disable_writes++;
      end
      if (arvalid && arready)
         axi_count++;
   end

   always @(posedge bus_clk)
   begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, %0d words still expected", cycle_count,
                  exp_q.size());
         $display("%0d words compared, %0d errors", word_count, error_count);
         $display("Checks failed");
         $finish;
      end
   end

   initial
   begin
      int a0;
      int w0;
      int d0;
      int e0;
      arst_n       = 1'b0;
      in_data      = '0;
      in_valid     = 1'b0;
      out_ready    = 1'b1;
      frame_req    = 1'b0;
      frame_lines  = 0;
      frame_pixels = 0;
      omit_le_line = -1;
      repeat (16) @(posedge bus_clk);
      #1;
      arst_n = 1'b1;

      // Reset state
      @(negedge bus_clk);
      if (in_ready !== 1'b1)
         report_mismatch("in_ready", in_ready, 1);
      if ({awvalid, wvalid, bready, arvalid, rready} !== 5'b0)
         report_mismatch("axi valid/ready", {awvalid, wvalid, bready, arvalid, rready}, 0);
      if (out_valid !== 1'b0)
         report_mismatch("out_valid", out_valid, 0);
      if (line_err_count !== '0)
         report_mismatch("line_err_count", line_err_count, 0);
      @(posedge bus_clk);
      #1;

      // Configuration writes read back
      send_cmd(8'h68);
      exp_q.push_back(32'd2);
      send_cmd(8'h67);
      send_cmd(8'h69);
      exp_q.push_back(32'd3);
      send_cmd(8'h67);
      wait_drained();
      if (rx_cfg !== 32'd3)
         report_mismatch("rx cfg_reg", rx_cfg, 3);

      // Unknown byte is dropped
      a0 = axi_count;
      w0 = word_count;
      send_cmd(8'h41);
      repeat (20) @(posedge bus_clk);
      #1;
      if (axi_count != a0)
         report_mismatch("axi transaction count", axi_count, a0);
      if (word_count != w0 || out_valid !== 1'b0)
         $display("FIFO word produced by an unknown command byte at %0t ns", $time);
      if (word_count != w0 || out_valid !== 1'b0)
         error_count++;
      exp_q.push_back(32'd0);
      send_cmd(8'h66);
      wait_drained();
      if (axi_count != a0 + 1)
         report_mismatch("axi transaction count", axi_count, a0 + 1);

      // Small frame, host always ready
      start_frame(2, 4, -1);
      expect_pixels(8);
      send_cmd(8'h63);
      wait_drained();
      exp_q.push_back(32'd0);
      send_cmd(8'h66);
      wait_drained();
      if (rx_ctrl !== 32'd0)
         report_mismatch("rx ctrl_reg", rx_ctrl, 0);

      // Host stalls until the first disable write, forcing a pause
      out_ready = 1'b0;
      d0        = disable_writes;
      start_frame(4, 10, -1);
      expect_pixels(40);
      send_cmd(8'h63);
      do @(posedge bus_clk); while (disable_writes == d0);
      #1;
      out_ready = 1'b1;
      wait_drained();
      exp_q.push_back(32'd0);
      send_cmd(8'h66);
      wait_drained();
      if (disable_writes - d0 < 2)
         $display("No pause write seen during the stalled capture at %0t ns", $time);
      if (disable_writes - d0 < 2)
         error_count++;

      // Missing le on the first line
      e0 = line_err_count;
      start_frame(3, 4, 0);
      expect_pixels(12);
      send_cmd(8'h63);
      wait_drained();
      exp_q.push_back(32'd0);
      send_cmd(8'h66);
      wait_drained();
      if (line_err_count !== LINE_ERR_W'(e0 + 1))
         report_mismatch("line_err_count", line_err_count, e0 + 1);

      repeat (10) @(posedge bus_clk);
      $display("%0d words compared, %0d errors", word_count, error_count);
      if (error_count == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: files.f
hw/cam_pkg.sv
hw/reg_req_if.sv
hw/cmd_decode.sv
hw/capture_ctrl.sv
hw/axil_reg_master.sv
hw/result_fifo.sv
hw/cam_bridge_top.sv
verif/csi_rx_model.sv
verif/tb_cam_bridge.sv
